// File: design/simt_pkg.sv
`default_nettype none

package simt_pkg;

    localparam int num_warps = 8;
    localparam int num_lanes = 8;
    localparam int lane_width = 32;
    localparam int num_regs = 8;

    localparam int warp_bits = $clog2(num_warps);
    localparam int reg_bits = $clog2(num_regs);

    // warp number, 0 to num_warps-1.
    typedef logic [warp_bits-1:0] warp_id_t;

    // register address within one warp.
    typedef logic [reg_bits-1:0] reg_addr_t;

    // one bit per lane, set for lanes that take part.
    typedef logic [num_lanes-1:0] lane_mask_t;

    // lane i sits in bits lane_width*i upward.
    typedef logic [num_lanes*lane_width-1:0] warp_data_t;

endpackage

`default_nettype wire

// File: design/wb_pkg.sv
`default_nettype none

package wb_pkg;

    // pending writes tracked per warp.
    localparam int scb_entries = 4;

    typedef logic [$clog2(scb_entries)-1:0] scb_id_t;

    // source of the result currently on the writeback bus.
    typedef enum logic [1:0]
    {
        grant_none,
        grant_alu,
        grant_held_mem
    } bus_grant_e;

endpackage

`default_nettype wire

// File: design/result_bus.sv
`timescale 1ns/1ns
`default_nettype none

module result_bus
(
    input wire clk,
    input wire reset,

    input wire alu_valid,
    input wire simt_pkg::warp_id_t alu_warp,
    input wire simt_pkg::reg_addr_t alu_dst,
    input wire wb_pkg::scb_id_t alu_scb_id,
    input wire simt_pkg::lane_mask_t alu_mask,
    input wire simt_pkg::warp_data_t alu_data,

    input wire mem_valid,
    input wire simt_pkg::warp_id_t mem_warp,
    input wire simt_pkg::reg_addr_t mem_dst,
    input wire wb_pkg::scb_id_t mem_scb_id,
    input wire simt_pkg::lane_mask_t mem_mask,
    input wire simt_pkg::warp_data_t mem_data,

    output logic wb_valid,
    output simt_pkg::warp_id_t wb_warp,
    output simt_pkg::reg_addr_t wb_dst,
    output wb_pkg::scb_id_t wb_scb_id,
    output simt_pkg::lane_mask_t wb_mask,
    output simt_pkg::warp_data_t wb_data
);

    simt_pkg::warp_id_t alu_warp_q;
    simt_pkg::reg_addr_t alu_dst_q;
    wb_pkg::scb_id_t alu_scb_id_q;
    simt_pkg::lane_mask_t alu_mask_q;
    simt_pkg::warp_data_t alu_data_q;

    // every MEM result passes through the hold register.
    simt_pkg::warp_id_t hold_warp;
    simt_pkg::reg_addr_t hold_dst;
    wb_pkg::scb_id_t hold_scb_id;
    simt_pkg::lane_mask_t hold_mask;
    simt_pkg::warp_data_t hold_data;
    logic hold_full; // set only while a MEM result waits behind the ALU.

    wb_pkg::bus_grant_e grant;
    wb_pkg::bus_grant_e grant_next;

    // the issue logic never sends an ALU strobe in the cycle after a conflict.
    always_comb
    begin
        if (hold_full)
            grant_next = wb_pkg::grant_held_mem;
        else if (alu_valid)
            grant_next = wb_pkg::grant_alu;
        else if (mem_valid)
            grant_next = wb_pkg::grant_held_mem;
        else
            grant_next = wb_pkg::grant_none;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            grant <= wb_pkg::grant_none;
            hold_full <= 1'b0;
        end
        else
        begin
            grant <= grant_next;
            hold_full <= !hold_full && mem_valid && alu_valid; // a full hold drains now.
        end
    end

    always_ff @(posedge clk)
    begin
        if (alu_valid)
        begin
            alu_warp_q <= alu_warp;
            alu_dst_q <= alu_dst;
            alu_scb_id_q <= alu_scb_id;
            alu_mask_q <= alu_mask;
            alu_data_q <= alu_data;
        end
        if (mem_valid && !hold_full)
        begin
            hold_warp <= mem_warp;
            hold_dst <= mem_dst;
            hold_scb_id <= mem_scb_id;
            hold_mask <= mem_mask;
            hold_data <= mem_data;
        end
    end

    assign wb_valid = (grant != wb_pkg::grant_none);

    always_comb
    begin
        if (grant == wb_pkg::grant_held_mem)
        begin
            wb_warp = hold_warp;
            wb_dst = hold_dst;
            wb_scb_id = hold_scb_id;
            wb_mask = hold_mask;
            wb_data = hold_data;
        end
        else
        begin
            wb_warp = alu_warp_q;
            wb_dst = alu_dst_q;
            wb_scb_id = alu_scb_id_q;
            wb_mask = alu_mask_q;
            wb_data = alu_data_q;
        end
    end

endmodule

`default_nettype wire

// File: design/scoreboard.sv
`timescale 1ns/1ns
`default_nettype none

module scoreboard
(
    input wire clk,
    input wire reset,

    input wire issue_valid,
    input wire simt_pkg::warp_id_t issue_warp,
    input wire wb_pkg::scb_id_t issue_scb_id,
    input wire simt_pkg::reg_addr_t issue_dst,

    input wire clr_valid,
    input wire simt_pkg::warp_id_t clr_warp,
    input wire wb_pkg::scb_id_t clr_scb_id,

    input wire simt_pkg::warp_id_t q_warp,
    input wire simt_pkg::reg_addr_t q_reg,
    output logic hazard
);

    logic ent_valid [simt_pkg::num_warps][wb_pkg::scb_entries];
    simt_pkg::reg_addr_t ent_dst [simt_pkg::num_warps][wb_pkg::scb_entries];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int w = 0; w < simt_pkg::num_warps; w++)
            begin
                for (int e = 0; e < wb_pkg::scb_entries; e++)
                begin
                    ent_valid[w][e] <= 1'b0;
                end
            end
        end
        else
        begin
            if (clr_valid)
                ent_valid[clr_warp][clr_scb_id] <= 1'b0;
            // issue comes last so it wins over a clear of the same entry.
            if (issue_valid)
                ent_valid[issue_warp][issue_scb_id] <= 1'b1;
        end
    end

    // only read while the valid bit is set.
    always_ff @(posedge clk)
    begin
        if (issue_valid)
            ent_dst[issue_warp][issue_scb_id] <= issue_dst;
    end

    // a register is hazardous while any pending entry of its warp targets it.
    always_comb
    begin
        hazard = 1'b0;
        for (int e = 0; e < wb_pkg::scb_entries; e++)
        begin
            if (ent_valid[q_warp][e] && (ent_dst[q_warp][e] == q_reg))
                hazard = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/lane_reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module lane_reg_file
(
    input wire clk,
    input wire reset,

    input wire wr_valid,
    input wire simt_pkg::warp_id_t wr_warp,
    input wire simt_pkg::reg_addr_t wr_addr,
    input wire simt_pkg::lane_mask_t wr_mask,
    input wire simt_pkg::warp_data_t wr_data,

    input wire simt_pkg::warp_id_t rd_warp,
    input wire simt_pkg::reg_addr_t rd_addr,
    output simt_pkg::warp_data_t rd_data
);

    localparam int lw = simt_pkg::lane_width;

    // one slice per lane so a masked write touches only its own lanes.
    logic [lw-1:0] regs [simt_pkg::num_warps][simt_pkg::num_regs][simt_pkg::num_lanes];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int w = 0; w < simt_pkg::num_warps; w++)
            begin
                for (int r = 0; r < simt_pkg::num_regs; r++)
                begin
                    for (int l = 0; l < simt_pkg::num_lanes; l++)
                    begin
                        regs[w][r][l] <= '0;
                    end
                end
            end
        end
        else if (wr_valid)
        begin
            for (int l = 0; l < simt_pkg::num_lanes; l++)
            begin
                if (wr_mask[l])
                    regs[wr_warp][wr_addr][l] <= wr_data[l*lw +: lw];
            end
        end
    end

    always_comb
    begin
        for (int l = 0; l < simt_pkg::num_lanes; l++)
        begin
            rd_data[l*lw +: lw] = regs[rd_warp][rd_addr][l]; // no bypass from the bus.
        end
    end

endmodule

`default_nettype wire

// File: design/writeback_top.sv
`timescale 1ns/1ns
`default_nettype none

module writeback_top
(
    input wire clk,
    input wire reset,

    input wire alu_valid,
    input wire simt_pkg::warp_id_t alu_warp,
    input wire simt_pkg::reg_addr_t alu_dst,
    input wire wb_pkg::scb_id_t alu_scb_id,
    input wire simt_pkg::lane_mask_t alu_mask,
    input wire simt_pkg::warp_data_t alu_data,

    input wire mem_valid,
    input wire simt_pkg::warp_id_t mem_warp,
    input wire simt_pkg::reg_addr_t mem_dst,
    input wire wb_pkg::scb_id_t mem_scb_id,
    input wire simt_pkg::lane_mask_t mem_mask,
    input wire simt_pkg::warp_data_t mem_data,

    input wire issue_valid,
    input wire simt_pkg::warp_id_t issue_warp,
    input wire wb_pkg::scb_id_t issue_scb_id,
    input wire simt_pkg::reg_addr_t issue_dst,

    input wire simt_pkg::warp_id_t q_warp,
    input wire simt_pkg::reg_addr_t q_reg,
    input wire simt_pkg::warp_id_t rd_warp,
    input wire simt_pkg::reg_addr_t rd_addr,

    output logic hazard,
    output simt_pkg::warp_data_t rd_data
);

    logic wb_valid;
    simt_pkg::warp_id_t wb_warp;
    simt_pkg::reg_addr_t wb_dst;
    wb_pkg::scb_id_t wb_scb_id;
    simt_pkg::lane_mask_t wb_mask;
    simt_pkg::warp_data_t wb_data;

    result_bus bus
    (
        .clk(clk), .reset(reset),
        .alu_valid(alu_valid), .alu_warp(alu_warp), .alu_dst(alu_dst),
        .alu_scb_id(alu_scb_id), .alu_mask(alu_mask), .alu_data(alu_data),
        .mem_valid(mem_valid), .mem_warp(mem_warp), .mem_dst(mem_dst),
        .mem_scb_id(mem_scb_id), .mem_mask(mem_mask), .mem_data(mem_data),
        .wb_valid(wb_valid), .wb_warp(wb_warp), .wb_dst(wb_dst),
        .wb_scb_id(wb_scb_id), .wb_mask(wb_mask), .wb_data(wb_data)
    );

    // the bus result frees its entry at the same edge as the register write.
    scoreboard scb
    (
        .clk(clk), .reset(reset),
        .issue_valid(issue_valid), .issue_warp(issue_warp),
        .issue_scb_id(issue_scb_id), .issue_dst(issue_dst),
        .clr_valid(wb_valid), .clr_warp(wb_warp), .clr_scb_id(wb_scb_id),
        .q_warp(q_warp), .q_reg(q_reg), .hazard(hazard)
    );

    lane_reg_file rf
    (
        .clk(clk), .reset(reset),
        .wr_valid(wb_valid), .wr_warp(wb_warp), .wr_addr(wb_dst),
        .wr_mask(wb_mask), .wr_data(wb_data),
        .rd_warp(rd_warp), .rd_addr(rd_addr), .rd_data(rd_data)
    );

endmodule

`default_nettype wire

// File: bench/writeback_checker.sv
`timescale 1ns/1ns
`default_nettype none

module writeback_checker
(
    input wire clk,
    input wire reset,
    input wire mem_valid,
    input wire hold_full,
    input wire wb_valid
);

    // the MEM unit leaves at least one idle cycle between two results.
    mem_spacing: assert property (@(posedge clk) disable iff (reset) mem_valid |=> !mem_valid)
        else $error("mem_valid was high in two consecutive cycles");

    hold_free: assert property (@(posedge clk) disable iff (reset) mem_valid |-> !hold_full)
        else $error("a MEM result arrived while the hold register was full");

    bus_idle_after_reset: assert property (@(posedge clk) reset |=> !wb_valid)
        else $error("the writeback bus was valid in the cycle after reset");

endmodule

bind result_bus writeback_checker bus_chk
(
    .clk(clk), .reset(reset), .mem_valid(mem_valid), .hold_full(hold_full),
    .wb_valid(wb_valid)
);

`default_nettype wire

// File: bench/writeback_tb.sv
`timescale 1ns/1ns
`default_nettype none

module writeback_tb;

    logic clk;
    logic reset;
    logic alu_valid;
    simt_pkg::warp_id_t alu_warp;
    simt_pkg::reg_addr_t alu_dst;
    wb_pkg::scb_id_t alu_scb_id;
    simt_pkg::lane_mask_t alu_mask;
    simt_pkg::warp_data_t alu_data;
    logic mem_valid;
    simt_pkg::warp_id_t mem_warp;
    simt_pkg::reg_addr_t mem_dst;
    wb_pkg::scb_id_t mem_scb_id;
    simt_pkg::lane_mask_t mem_mask;
    simt_pkg::warp_data_t mem_data;
    logic issue_valid;
    simt_pkg::warp_id_t issue_warp;
    wb_pkg::scb_id_t issue_scb_id;
    simt_pkg::reg_addr_t issue_dst;
    simt_pkg::warp_id_t q_warp;
    simt_pkg::reg_addr_t q_reg;
    simt_pkg::warp_id_t rd_warp;
    simt_pkg::reg_addr_t rd_addr;
    logic hazard;
    simt_pkg::warp_data_t rd_data;

    // reference state, advanced once per cycle in step with the DUT.
    simt_pkg::warp_data_t model_rf [simt_pkg::num_warps][simt_pkg::num_regs];
    logic model_valid [simt_pkg::num_warps][wb_pkg::scb_entries];
    simt_pkg::reg_addr_t model_dst [simt_pkg::num_warps][wb_pkg::scb_entries];

    // results in the order in which they reach the writeback bus, one per cycle.
    simt_pkg::warp_id_t bus_warp [$];
    simt_pkg::reg_addr_t bus_dst [$];
    wb_pkg::scb_id_t bus_scb_id [$];
    simt_pkg::lane_mask_t bus_mask [$];
    simt_pkg::warp_data_t bus_data [$];

    string exp_name [$];
    simt_pkg::warp_data_t exp_rd [$];
    logic exp_hazard [$];

    logic [31:0] rand_state;
    logic [31:0] rnd;
    logic do_alu;
    logic do_mem;
    logic prev_mem;
    logic prev_conflict;
    int cycles;
    int cycle_limit;

    writeback_top uut (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rand_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rand_state = x;
        return x;
    endfunction

    function automatic simt_pkg::warp_data_t random_data();
        simt_pkg::warp_data_t d;
        for (int l = 0; l < simt_pkg::num_lanes; l++)
            d[l*simt_pkg::lane_width +: simt_pkg::lane_width] = next_random();
        return d;
    endfunction

    function automatic simt_pkg::warp_data_t merge_lanes(input simt_pkg::warp_data_t old_val,
        input simt_pkg::warp_data_t new_val, input simt_pkg::lane_mask_t mask);
        simt_pkg::warp_data_t res;
        res = old_val;
        for (int l = 0; l < simt_pkg::num_lanes; l++)
        begin
            if (mask[l])
                res[l*simt_pkg::lane_width +: simt_pkg::lane_width] =
                    new_val[l*simt_pkg::lane_width +: simt_pkg::lane_width];
        end
        return res;
    endfunction

    function automatic logic model_hazard(input simt_pkg::warp_id_t w,
        input simt_pkg::reg_addr_t r);
        logic hit;
        hit = 1'b0;
        for (int e = 0; e < wb_pkg::scb_entries; e++)
        begin
            if (model_valid[w][e] && (model_dst[w][e] == r))
                hit = 1'b1;
        end
        return hit;
    endfunction

    task automatic check_value(input string name, input simt_pkg::warp_data_t expected,
        input simt_pkg::warp_data_t actual);
        if (actual !== expected)
        begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic send_alu(input simt_pkg::warp_id_t w, input simt_pkg::reg_addr_t r,
        input wb_pkg::scb_id_t e, input simt_pkg::lane_mask_t m, input simt_pkg::warp_data_t d);
        alu_valid = 1'b1;
        alu_warp = w;
        alu_dst = r;
        alu_scb_id = e;
        alu_mask = m;
        alu_data = d;
    endtask

    task automatic send_mem(input simt_pkg::warp_id_t w, input simt_pkg::reg_addr_t r,
        input wb_pkg::scb_id_t e, input simt_pkg::lane_mask_t m, input simt_pkg::warp_data_t d);
        mem_valid = 1'b1;
        mem_warp = w;
        mem_dst = r;
        mem_scb_id = e;
        mem_mask = m;
        mem_data = d;
    endtask

    task automatic send_issue(input simt_pkg::warp_id_t w, input wb_pkg::scb_id_t e,
        input simt_pkg::reg_addr_t r);
        issue_valid = 1'b1;
        issue_warp = w;
        issue_scb_id = e;
        issue_dst = r;
    endtask

    task automatic point_at(input simt_pkg::warp_id_t w, input simt_pkg::reg_addr_t r);
        rd_warp = w;
        rd_addr = r;
        q_warp = w;
        q_reg = r;
    endtask

    // records what the DUT must show in this cycle, then applies the edge that ends it.
    task automatic next_cycle(input string name);
        simt_pkg::warp_id_t w;
        simt_pkg::reg_addr_t r;
        wb_pkg::scb_id_t e;
        simt_pkg::lane_mask_t m;
        simt_pkg::warp_data_t d;
        exp_name.push_back(name);
        exp_rd.push_back(model_rf[rd_warp][rd_addr]);
        exp_hazard.push_back(model_hazard(q_warp, q_reg));
        if (bus_warp.size() > 0)
        begin
            w = bus_warp.pop_front();
            r = bus_dst.pop_front();
            e = bus_scb_id.pop_front();
            m = bus_mask.pop_front();
            d = bus_data.pop_front();
            model_rf[w][r] = merge_lanes(model_rf[w][r], d, m);
            model_valid[w][e] = 1'b0;
        end
        if (issue_valid)
        begin
            model_valid[issue_warp][issue_scb_id] = 1'b1; // wins over a clear at this edge.
            model_dst[issue_warp][issue_scb_id] = issue_dst;
        end
        if (alu_valid)
        begin
            bus_warp.push_back(alu_warp);
            bus_dst.push_back(alu_dst);
            bus_scb_id.push_back(alu_scb_id);
            bus_mask.push_back(alu_mask);
            bus_data.push_back(alu_data);
        end
        if (mem_valid)
        begin
            bus_warp.push_back(mem_warp);
            bus_dst.push_back(mem_dst);
            bus_scb_id.push_back(mem_scb_id);
            bus_mask.push_back(mem_mask);
            bus_data.push_back(mem_data);
        end
        @(negedge clk);
        alu_valid = 1'b0;
        mem_valid = 1'b0;
        issue_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n, input string name);
        repeat (n) next_cycle(name);
    endtask

    task automatic sweep_all(input string name);
        for (int w = 0; w < simt_pkg::num_warps; w++)
        begin
            for (int r = 0; r < simt_pkg::num_regs; r++)
            begin
                point_at(simt_pkg::warp_id_t'(w), simt_pkg::reg_addr_t'(r));
                next_cycle(name);
            end
        end
    endtask

    // outputs are sampled at the rising edge, before that edge's updates land.
    initial
    begin
        string name;
        simt_pkg::warp_data_t want_rd;
        logic want_hazard;
        forever
        begin
            @(posedge clk);
            if (exp_name.size() > 0)
            begin
                name = exp_name.pop_front();
                want_rd = exp_rd.pop_front();
                want_hazard = exp_hazard.pop_front();
                check_value({name, " rd_data"}, want_rd, rd_data);
                check_value({name, " hazard"}, {255'b0, want_hazard}, {255'b0, hazard});
            end
        end
    end

    // the tests take about 1150 cycles.
    initial
    begin
        cycles = 0;
        cycle_limit = 3000;
        while (cycles < cycle_limit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
        $display("CHECKS FAILED");
        $fatal(1, "cycle limit reached");
    end

    initial
    begin
        rand_state = 32'hc938_1004;
        prev_mem = 1'b0;
        prev_conflict = 1'b0;
        reset = 1'b1;
        send_alu('0, '0, '0, '0, '0);
        send_mem('0, '0, '0, '0, '0);
        send_issue('0, '0, '0);
        alu_valid = 1'b0;
        mem_valid = 1'b0;
        issue_valid = 1'b0;
        point_at('0, '0);
        for (int w = 0; w < simt_pkg::num_warps; w++)
        begin
            for (int r = 0; r < simt_pkg::num_regs; r++)
                model_rf[w][r] = '0;
            for (int e = 0; e < wb_pkg::scb_entries; e++)
            begin
                model_valid[w][e] = 1'b0;
                model_dst[w][e] = '0;
            end
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        sweep_all("reset_state");

        point_at(3'd2, 3'd3);
        send_alu(3'd2, 3'd3, 2'd0, 8'hff, random_data());
        next_cycle("alu_full_mask");
        idle_cycles(2, "alu_full_mask");
        send_alu(3'd2, 3'd3, 2'd1, 8'ha5, random_data());
        next_cycle("alu_partial_mask");
        idle_cycles(3, "alu_partial_mask");

        point_at(3'd4, 3'd1);
        send_mem(3'd4, 3'd1, 2'd0, 8'hff, random_data());
        next_cycle("mem_lone");
        idle_cycles(2, "mem_lone");
        send_alu(3'd4, 3'd1, 2'd1, 8'h3c, random_data()); // lanes 2 and 3 end with MEM data.
        send_mem(3'd4, 3'd1, 2'd2, 8'h0f, random_data());
        next_cycle("mem_conflict");
        idle_cycles(4, "mem_conflict");

        point_at(3'd5, 3'd6);
        send_issue(3'd5, 2'd0, 3'd6);
        idle_cycles(2, "hazard_issue");
        point_at(3'd6, 3'd6);
        next_cycle("hazard_other_warp");
        point_at(3'd5, 3'd6);
        send_issue(3'd5, 2'd1, 3'd6);
        next_cycle("hazard_second_entry");
        send_alu(3'd5, 3'd6, 2'd0, 8'hff, random_data());
        next_cycle("hazard_first_clear");
        idle_cycles(3, "hazard_first_clear");
        send_mem(3'd5, 3'd6, 2'd1, 8'hff, random_data());
        next_cycle("hazard_second_clear");
        idle_cycles(3, "hazard_second_clear");

        repeat (1000)
        begin
            rnd = next_random();
            do_alu = !prev_conflict && rnd[0]; // a held MEM result owns the next bus cycle.
            do_mem = !prev_mem && (rnd[2:1] != 2'b00);
            if (do_alu)
                send_alu(rnd[5:3], rnd[8:6], rnd[10:9], rnd[18:11], random_data());
            rnd = next_random();
            if (do_mem)
                send_mem(rnd[2:0], rnd[5:3], rnd[7:6], rnd[15:8], random_data());
            if (rnd[16])
                send_issue(rnd[19:17], rnd[21:20], rnd[24:22]);
            point_at(rnd[27:25], rnd[30:28]);
            prev_mem = do_mem;
            prev_conflict = do_alu && do_mem;
            next_cycle("random_traffic");
        end
        idle_cycles(3, "random_drain");
        sweep_all("final_sweep");

        while (exp_name.size() != 0)
            @(posedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: writeback.f
design/simt_pkg.sv
design/wb_pkg.sv
design/result_bus.sv
design/scoreboard.sv
design/lane_reg_file.sv
design/writeback_top.sv
bench/writeback_checker.sv
bench/writeback_tb.sv

// File: run.sh
#!/bin/sh
# Builds the writeback testbench with Verilator and runs it.
# The exit status of the simulation decides pass or fail.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f writeback.f --top-module writeback_tb \
    -Mdir obj_dir -o writeback_sim
./obj_dir/writeback_sim
